//--- source/vrf_pkg.sv
package vrf_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Data word and its byte lanes
  localparam int unsigned WORD_WIDTH = 32;
  localparam int unsigned BE_WIDTH   = 4;
  localparam int unsigned BYTE_WIDTH = WORD_WIDTH / BE_WIDTH;

  // Register file geometry
  localparam int unsigned NR_VREG        = 8;
  localparam int unsigned WORDS_PER_VREG = 8;
  localparam int unsigned NR_BANKS       = 4;
  localparam int unsigned ROWS_PER_BANK  = NR_VREG * WORDS_PER_VREG / NR_BANKS;

  // Port counts
  localparam int unsigned NR_WRITE_PORTS = 3;
  localparam int unsigned NR_READ_PORTS  = 5;
  localparam int unsigned NR_BANK_SLOTS  = 3;

  ////////////////////////////////////////
  // Derived widths
  ////////////////////////////////////////

  localparam int unsigned ADDR_WIDTH = $clog2(NR_VREG * WORDS_PER_VREG);
  localparam int unsigned BANK_WIDTH = $clog2(NR_BANKS);
  localparam int unsigned ROW_WIDTH  = $clog2(ROWS_PER_BANK);
  localparam int unsigned SLOT_WIDTH = $clog2(NR_BANK_SLOTS);

  ////////////////////////////////////////
  // Port indices
  ////////////////////////////////////////

  // Write ports, lower index wins a bank
  localparam int unsigned FU_WR   = 0;
  localparam int unsigned LSU_WR  = 1;
  localparam int unsigned SLDU_WR = 2;

  // Read ports
  localparam int unsigned FU_VS2_RD = 0;
  localparam int unsigned FU_VS1_RD = 1;
  localparam int unsigned FU_VD_RD  = 2;
  localparam int unsigned LSU_RD    = 3;
  localparam int unsigned SLDU_RD   = 4;

  // Bank read slots
  // Slot 0 takes vs2 then the slide unit, slot 1 takes vs1 then the LSU
  localparam int unsigned SLOT_VS2 = 0;
  localparam int unsigned SLOT_VS1 = 1;
  localparam int unsigned SLOT_VD  = 2;

  ////////////////////////////////////////
  // Address word
  ////////////////////////////////////////

  // Words of a register are interleaved over the banks
  typedef struct packed {
    logic [ROW_WIDTH-1:0]  row;
    logic [BANK_WIDTH-1:0] bank;
  } vrf_addr_fields_t;

  // Flat view is vreg * WORDS_PER_VREG + word
  typedef union packed {
    logic [ADDR_WIDTH-1:0] flat;
    vrf_addr_fields_t      fields;
  } vrf_addr_u;

endpackage

//--- source/vrf_request_router.sv
`timescale 1ns/1ps

module vrf_request_router (
  // Write requests
  input  vrf_pkg::vrf_addr_u [vrf_pkg::NR_WRITE_PORTS-1:0]                        waddr_i,
  input  logic [vrf_pkg::NR_WRITE_PORTS-1:0][vrf_pkg::WORD_WIDTH-1:0]             wdata_i,
  input  logic [vrf_pkg::NR_WRITE_PORTS-1:0][vrf_pkg::BE_WIDTH-1:0]               wbe_i,
  input  logic [vrf_pkg::NR_WRITE_PORTS-1:0]                                      we_i,
  output logic [vrf_pkg::NR_WRITE_PORTS-1:0]                                      wvalid_o,
  // Read requests
  input  vrf_pkg::vrf_addr_u [vrf_pkg::NR_READ_PORTS-1:0]                         raddr_i,
  input  logic [vrf_pkg::NR_READ_PORTS-1:0]                                       re_i,
  // Bank write side
  output logic [vrf_pkg::NR_BANKS-1:0]                                            bank_we_o,
  output logic [vrf_pkg::NR_BANKS-1:0][vrf_pkg::ROW_WIDTH-1:0]                    bank_waddr_o,
  output logic [vrf_pkg::NR_BANKS-1:0][vrf_pkg::WORD_WIDTH-1:0]                   bank_wdata_o,
  output logic [vrf_pkg::NR_BANKS-1:0][vrf_pkg::BE_WIDTH-1:0]                     bank_wbe_o,
  // Bank read side
  output logic [vrf_pkg::NR_BANKS-1:0][vrf_pkg::NR_BANK_SLOTS-1:0][vrf_pkg::ROW_WIDTH-1:0]
                                                                                  bank_raddr_o,
  // Per read port grant and location
  output logic [vrf_pkg::NR_READ_PORTS-1:0]                                       rgrant_o,
  output logic [vrf_pkg::NR_READ_PORTS-1:0][vrf_pkg::BANK_WIDTH-1:0]              rbank_o,
  output logic [vrf_pkg::NR_READ_PORTS-1:0][vrf_pkg::SLOT_WIDTH-1:0]              rslot_o
);

  ////////////////////////////////////////
  // Request decode
  ////////////////////////////////////////

  logic [vrf_pkg::NR_BANKS-1:0][vrf_pkg::NR_WRITE_PORTS-1:0] write_req;
  logic [vrf_pkg::NR_BANKS-1:0][vrf_pkg::NR_READ_PORTS-1:0]  read_req;

  for (genvar b = 0; b < vrf_pkg::NR_BANKS; b++) begin : gen_req
    for (genvar w = 0; w < vrf_pkg::NR_WRITE_PORTS; w++) begin : gen_wreq
      assign write_req[b][w] = we_i[w] &&
                               (waddr_i[w].fields.bank == vrf_pkg::BANK_WIDTH'(b));
    end
    for (genvar r = 0; r < vrf_pkg::NR_READ_PORTS; r++) begin : gen_rreq
      assign read_req[b][r] = re_i[r] &&
                              (raddr_i[r].fields.bank == vrf_pkg::BANK_WIDTH'(b));
    end
  end

  ////////////////////////////////////////
  // Write arbitration
  ////////////////////////////////////////

  always_comb begin : proc_write
    bank_we_o    = '0;
    bank_waddr_o = '0;
    bank_wdata_o = '0;
    bank_wbe_o   = '0;
    wvalid_o     = '0;

    // Functional unit first, then LSU, then slide unit
    for (int unsigned b = 0; b < vrf_pkg::NR_BANKS; b++) begin
      if (write_req[b][vrf_pkg::FU_WR]) begin
        bank_we_o[b]             = 1'b1;
        bank_waddr_o[b]          = waddr_i[vrf_pkg::FU_WR].fields.row;
        bank_wdata_o[b]          = wdata_i[vrf_pkg::FU_WR];
        bank_wbe_o[b]            = wbe_i[vrf_pkg::FU_WR];
        wvalid_o[vrf_pkg::FU_WR] = 1'b1;
      end else if (write_req[b][vrf_pkg::LSU_WR]) begin
        bank_we_o[b]              = 1'b1;
        bank_waddr_o[b]           = waddr_i[vrf_pkg::LSU_WR].fields.row;
        bank_wdata_o[b]           = wdata_i[vrf_pkg::LSU_WR];
        bank_wbe_o[b]             = wbe_i[vrf_pkg::LSU_WR];
        wvalid_o[vrf_pkg::LSU_WR] = 1'b1;
      end else if (write_req[b][vrf_pkg::SLDU_WR]) begin
        bank_we_o[b]               = 1'b1;
        bank_waddr_o[b]            = waddr_i[vrf_pkg::SLDU_WR].fields.row;
        bank_wdata_o[b]            = wdata_i[vrf_pkg::SLDU_WR];
        bank_wbe_o[b]              = wbe_i[vrf_pkg::SLDU_WR];
        wvalid_o[vrf_pkg::SLDU_WR] = 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Read slot arbitration
  ////////////////////////////////////////

  always_comb begin : proc_read
    bank_raddr_o = '0;
    rgrant_o     = '0;
    rbank_o      = '0;
    rslot_o      = '0;

    for (int unsigned b = 0; b < vrf_pkg::NR_BANKS; b++) begin
      // Slot 0, vs2 ahead of the slide unit
      if (read_req[b][vrf_pkg::FU_VS2_RD]) begin
        bank_raddr_o[b][vrf_pkg::SLOT_VS2] = raddr_i[vrf_pkg::FU_VS2_RD].fields.row;
        rgrant_o[vrf_pkg::FU_VS2_RD]       = 1'b1;
        rbank_o[vrf_pkg::FU_VS2_RD]        = vrf_pkg::BANK_WIDTH'(b);
        rslot_o[vrf_pkg::FU_VS2_RD]        = vrf_pkg::SLOT_WIDTH'(vrf_pkg::SLOT_VS2);
      end else if (read_req[b][vrf_pkg::SLDU_RD]) begin
        bank_raddr_o[b][vrf_pkg::SLOT_VS2] = raddr_i[vrf_pkg::SLDU_RD].fields.row;
        rgrant_o[vrf_pkg::SLDU_RD]         = 1'b1;
        rbank_o[vrf_pkg::SLDU_RD]          = vrf_pkg::BANK_WIDTH'(b);
        rslot_o[vrf_pkg::SLDU_RD]          = vrf_pkg::SLOT_WIDTH'(vrf_pkg::SLOT_VS2);
      end

      // Slot 1, vs1 ahead of the LSU
      if (read_req[b][vrf_pkg::FU_VS1_RD]) begin
        bank_raddr_o[b][vrf_pkg::SLOT_VS1] = raddr_i[vrf_pkg::FU_VS1_RD].fields.row;
        rgrant_o[vrf_pkg::FU_VS1_RD]       = 1'b1;
        rbank_o[vrf_pkg::FU_VS1_RD]        = vrf_pkg::BANK_WIDTH'(b);
        rslot_o[vrf_pkg::FU_VS1_RD]        = vrf_pkg::SLOT_WIDTH'(vrf_pkg::SLOT_VS1);
      end else if (read_req[b][vrf_pkg::LSU_RD]) begin
        bank_raddr_o[b][vrf_pkg::SLOT_VS1] = raddr_i[vrf_pkg::LSU_RD].fields.row;
        rgrant_o[vrf_pkg::LSU_RD]          = 1'b1;
        rbank_o[vrf_pkg::LSU_RD]           = vrf_pkg::BANK_WIDTH'(b);
        rslot_o[vrf_pkg::LSU_RD]           = vrf_pkg::SLOT_WIDTH'(vrf_pkg::SLOT_VS1);
      end

      // Slot 2 belongs to vd alone
      if (read_req[b][vrf_pkg::FU_VD_RD]) begin
        bank_raddr_o[b][vrf_pkg::SLOT_VD] = raddr_i[vrf_pkg::FU_VD_RD].fields.row;
        rgrant_o[vrf_pkg::FU_VD_RD]       = 1'b1;
        rbank_o[vrf_pkg::FU_VD_RD]        = vrf_pkg::BANK_WIDTH'(b);
        rslot_o[vrf_pkg::FU_VD_RD]        = vrf_pkg::SLOT_WIDTH'(vrf_pkg::SLOT_VD);
      end
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  for (genvar b = 0; b < vrf_pkg::NR_BANKS; b++) begin : gen_wr_check
    a_one_write_per_bank: assert final ($onehot0(write_req[b] & wvalid_o))
      else $error("vrf_request_router: several writes granted on bank %0d", b);
  end

  a_grant_has_request: assert final ((rgrant_o & ~re_i) == '0)
    else $error("vrf_request_router: read granted without request");

endmodule

//--- source/vrf_bank.sv
`timescale 1ns/1ps

module vrf_bank (
  input  logic                                                          clk_i,
  input  logic                                                          rst_i,
  // Write port
  input  logic                                                          we_i,
  input  logic [vrf_pkg::ROW_WIDTH-1:0]                                 waddr_i,
  input  logic [vrf_pkg::WORD_WIDTH-1:0]                                wdata_i,
  input  logic [vrf_pkg::BE_WIDTH-1:0]                                  wbe_i,
  // Read slots
  input  logic [vrf_pkg::NR_BANK_SLOTS-1:0][vrf_pkg::ROW_WIDTH-1:0]     raddr_i,
  output logic [vrf_pkg::NR_BANK_SLOTS-1:0][vrf_pkg::WORD_WIDTH-1:0]    rdata_o
);

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  logic [vrf_pkg::ROWS_PER_BANK-1:0][vrf_pkg::WORD_WIDTH-1:0] mem_q;

  // Register contents read as zero after reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mem_q <= '0;
    end else if (we_i) begin
      for (int unsigned i = 0; i < vrf_pkg::BE_WIDTH; i++) begin
        if (wbe_i[i]) begin
          mem_q[waddr_i][i*vrf_pkg::BYTE_WIDTH +: vrf_pkg::BYTE_WIDTH] <=
            wdata_i[i*vrf_pkg::BYTE_WIDTH +: vrf_pkg::BYTE_WIDTH];
        end
      end
    end
  end

  ////////////////////////////////////////
  // Read slots
  ////////////////////////////////////////

  // A read in the write cycle still returns the old word
  always_comb begin
    for (int unsigned s = 0; s < vrf_pkg::NR_BANK_SLOTS; s++) begin
      rdata_o[s] = mem_q[raddr_i[s]];
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  a_we_known: assert property (@(posedge clk_i) disable iff (rst_i)
    !$isunknown(we_i))
    else $error("vrf_bank: write enable unknown");

endmodule

//--- source/vrf_read_return.sv
`timescale 1ns/1ps

module vrf_read_return (
  // Slot data from all banks
  input  logic [vrf_pkg::NR_BANKS-1:0][vrf_pkg::NR_BANK_SLOTS-1:0][vrf_pkg::WORD_WIDTH-1:0]
                                                                      bank_rdata_i,
  // Grant and location per read port
  input  logic [vrf_pkg::NR_READ_PORTS-1:0]                           rgrant_i,
  input  logic [vrf_pkg::NR_READ_PORTS-1:0][vrf_pkg::BANK_WIDTH-1:0]  rbank_i,
  input  logic [vrf_pkg::NR_READ_PORTS-1:0][vrf_pkg::SLOT_WIDTH-1:0]  rslot_i,
  // Read results
  output logic [vrf_pkg::NR_READ_PORTS-1:0][vrf_pkg::WORD_WIDTH-1:0]  rdata_o,
  output logic [vrf_pkg::NR_READ_PORTS-1:0]                           rvalid_o
);

  ////////////////////////////////////////
  // Data select
  ////////////////////////////////////////

  // Ungranted ports return zero
  always_comb begin
    for (int unsigned p = 0; p < vrf_pkg::NR_READ_PORTS; p++) begin
      if (rgrant_i[p]) begin
        rdata_o[p] = bank_rdata_i[rbank_i[p]][rslot_i[p]];
      end else begin
        rdata_o[p] = '0;
      end
    end
  end

  assign rvalid_o = rgrant_i;

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Each bank slot drives at most one port
  for (genvar p = 0; p < vrf_pkg::NR_READ_PORTS; p++) begin : gen_port_a
    for (genvar q = p + 1; q < vrf_pkg::NR_READ_PORTS; q++) begin : gen_port_b
      a_slot_unique: assert final (!(rgrant_i[p] && rgrant_i[q] &&
                                     (rbank_i[p] == rbank_i[q]) &&
                                     (rslot_i[p] == rslot_i[q])))
        else $error("vrf_read_return: ports %0d and %0d share bank %0d slot %0d",
                    p, q, rbank_i[p], rslot_i[p]);
    end
  end

endmodule

//--- source/vrf_top.sv
`timescale 1ns/1ps

module vrf_top (
  input  logic                                                        clk_i,
  input  logic                                                        rst_i,
  // Write ports
  input  vrf_pkg::vrf_addr_u [vrf_pkg::NR_WRITE_PORTS-1:0]            waddr_i,
  input  logic [vrf_pkg::NR_WRITE_PORTS-1:0][vrf_pkg::WORD_WIDTH-1:0] wdata_i,
  input  logic [vrf_pkg::NR_WRITE_PORTS-1:0][vrf_pkg::BE_WIDTH-1:0]   wbe_i,
  input  logic [vrf_pkg::NR_WRITE_PORTS-1:0]                          we_i,
  output logic [vrf_pkg::NR_WRITE_PORTS-1:0]                          wvalid_o,
  // Read ports
  input  vrf_pkg::vrf_addr_u [vrf_pkg::NR_READ_PORTS-1:0]             raddr_i,
  input  logic [vrf_pkg::NR_READ_PORTS-1:0]                           re_i,
  output logic [vrf_pkg::NR_READ_PORTS-1:0][vrf_pkg::WORD_WIDTH-1:0]  rdata_o,
  output logic [vrf_pkg::NR_READ_PORTS-1:0]                           rvalid_o
);

  ////////////////////////////////////////
  // Internal wiring
  ////////////////////////////////////////

  // Per bank write
  logic [vrf_pkg::NR_BANKS-1:0]                          bank_we;
  logic [vrf_pkg::NR_BANKS-1:0][vrf_pkg::ROW_WIDTH-1:0]  bank_waddr;
  logic [vrf_pkg::NR_BANKS-1:0][vrf_pkg::WORD_WIDTH-1:0] bank_wdata;
  logic [vrf_pkg::NR_BANKS-1:0][vrf_pkg::BE_WIDTH-1:0]   bank_wbe;

  // Per bank and slot read
  logic [vrf_pkg::NR_BANKS-1:0][vrf_pkg::NR_BANK_SLOTS-1:0][vrf_pkg::ROW_WIDTH-1:0]  bank_raddr;
  logic [vrf_pkg::NR_BANKS-1:0][vrf_pkg::NR_BANK_SLOTS-1:0][vrf_pkg::WORD_WIDTH-1:0] bank_rdata;

  // Read grants
  logic [vrf_pkg::NR_READ_PORTS-1:0]                          rgrant;
  logic [vrf_pkg::NR_READ_PORTS-1:0][vrf_pkg::BANK_WIDTH-1:0] rbank;
  logic [vrf_pkg::NR_READ_PORTS-1:0][vrf_pkg::SLOT_WIDTH-1:0] rslot;

  vrf_request_router u_router (
    .waddr_i      (waddr_i),
    .wdata_i      (wdata_i),
    .wbe_i        (wbe_i),
    .we_i         (we_i),
    .wvalid_o     (wvalid_o),
    .raddr_i      (raddr_i),
    .re_i         (re_i),
    .bank_we_o    (bank_we),
    .bank_waddr_o (bank_waddr),
    .bank_wdata_o (bank_wdata),
    .bank_wbe_o   (bank_wbe),
    .bank_raddr_o (bank_raddr),
    .rgrant_o     (rgrant),
    .rbank_o      (rbank),
    .rslot_o      (rslot)
  );

  ////////////////////////////////////////
  // Banks
  ////////////////////////////////////////

  for (genvar b = 0; b < vrf_pkg::NR_BANKS; b++) begin : gen_banks
    vrf_bank u_bank (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .we_i    (bank_we[b]),
      .waddr_i (bank_waddr[b]),
      .wdata_i (bank_wdata[b]),
      .wbe_i   (bank_wbe[b]),
      .raddr_i (bank_raddr[b]),
      .rdata_o (bank_rdata[b])
    );
  end

  vrf_read_return u_read_return (
    .bank_rdata_i (bank_rdata),
    .rgrant_i     (rgrant),
    .rbank_i      (rbank),
    .rslot_i      (rslot),
    .rdata_o      (rdata_o),
    .rvalid_o     (rvalid_o)
  );

endmodule

//--- bench/vrf_tb.sv
`timescale 1ns/1ps

module vrf_tb;

  // Cycles spent by each test at one request per cycle
  localparam int unsigned RESET_CYCLES   = 10;
  localparam int unsigned CLEAR_CYCLES   = 64;
  localparam int unsigned READBK_CYCLES  = 128;
  localparam int unsigned PARTIAL_CYCLES = 32;
  localparam int unsigned WARB_CYCLES    = 52;
  localparam int unsigned RARB_CYCLES    = 19;
  localparam int unsigned RDWR_CYCLES    = 16;
  localparam int unsigned TIMEOUT_CYCLES = RESET_CYCLES + CLEAR_CYCLES + READBK_CYCLES +
                                           PARTIAL_CYCLES + WARB_CYCLES + RARB_CYCLES +
                                           RDWR_CYCLES + 100;

  logic clk;
  logic rst;

  vrf_pkg::vrf_addr_u [vrf_pkg::NR_WRITE_PORTS-1:0]            waddr;
  logic [vrf_pkg::NR_WRITE_PORTS-1:0][vrf_pkg::WORD_WIDTH-1:0] wdata;
  logic [vrf_pkg::NR_WRITE_PORTS-1:0][vrf_pkg::BE_WIDTH-1:0]   wbe;
  logic [vrf_pkg::NR_WRITE_PORTS-1:0]                          we;
  logic [vrf_pkg::NR_WRITE_PORTS-1:0]                          wvalid;
  vrf_pkg::vrf_addr_u [vrf_pkg::NR_READ_PORTS-1:0]             raddr;
  logic [vrf_pkg::NR_READ_PORTS-1:0]                           re;
  logic [vrf_pkg::NR_READ_PORTS-1:0][vrf_pkg::WORD_WIDTH-1:0]  rdata;
  logic [vrf_pkg::NR_READ_PORTS-1:0]                           rvalid;

  // Reference model state
  logic [vrf_pkg::WORD_WIDTH-1:0] ref_mem [vrf_pkg::NR_VREG*vrf_pkg::WORDS_PER_VREG];
  logic [vrf_pkg::NR_READ_PORTS-1:0][vrf_pkg::WORD_WIDTH-1:0] exp_rdata;
  logic [vrf_pkg::NR_WRITE_PORTS-1:0] exp_wvalid;
  logic [vrf_pkg::NR_READ_PORTS-1:0]  exp_rvalid;

  integer      seed;
  string       test_name;
  int unsigned err_count;
  int unsigned test_err_base;
  int unsigned pass_count;
  int unsigned fail_count;
  int unsigned cycle_count = 0;

  vrf_top uut (
    .clk_i    (clk),
    .rst_i    (rst),
    .waddr_i  (waddr),
    .wdata_i  (wdata),
    .wbe_i    (wbe),
    .we_i     (we),
    .wvalid_o (wvalid),
    .raddr_i  (raddr),
    .re_i     (re),
    .rdata_o  (rdata),
    .rvalid_o (rvalid)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Words are spread over the banks by the low address bits
  function automatic int unsigned bank_of(input vrf_pkg::vrf_addr_u addr);
    return addr.flat % vrf_pkg::NR_BANKS;
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < vrf_pkg::NR_VREG * vrf_pkg::WORDS_PER_VREG; i++) begin
        ref_mem[i] <= '0;
      end
    end else begin
      for (int unsigned w = 0; w < vrf_pkg::NR_WRITE_PORTS; w++) begin
        for (int unsigned b = 0; b < vrf_pkg::BE_WIDTH; b++) begin
          if (we[w] && wvalid[w] && wbe[w][b]) begin
            ref_mem[waddr[w].flat][b*8 +: 8] <= wdata[w][b*8 +: 8];
          end
        end
      end
    end
  end

  always_comb begin
    for (int unsigned p = 0; p < vrf_pkg::NR_READ_PORTS; p++) begin
      exp_rdata[p] = ref_mem[raddr[p].flat];
    end
    // Lower write index wins its bank
    exp_wvalid = we;
    for (int unsigned w = 1; w < vrf_pkg::NR_WRITE_PORTS; w++) begin
      for (int unsigned v = 0; v < w; v++) begin
        if (we[v] && (bank_of(waddr[v]) == bank_of(waddr[w]))) begin
          exp_wvalid[w] = 1'b0;
        end
      end
    end
    exp_rvalid = re;
    if (re[vrf_pkg::FU_VS2_RD] &&
        (bank_of(raddr[vrf_pkg::FU_VS2_RD]) == bank_of(raddr[vrf_pkg::SLDU_RD]))) begin
      exp_rvalid[vrf_pkg::SLDU_RD] = 1'b0;
    end
    if (re[vrf_pkg::FU_VS1_RD] &&
        (bank_of(raddr[vrf_pkg::FU_VS1_RD]) == bank_of(raddr[vrf_pkg::LSU_RD]))) begin
      exp_rvalid[vrf_pkg::LSU_RD] = 1'b0;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic report_mismatch(input string check, input logic [31:0] expected,
                                 input logic [31:0] actual);
    err_count++;
    $display("error in %s, %s: expected %h, actual %h", test_name, check, expected, actual);
  endtask

  a_write_grant: assert property (@(posedge clk) disable iff (rst) wvalid == exp_wvalid)
    else report_mismatch("write grant", 32'($sampled(exp_wvalid)), 32'($sampled(wvalid)));

  a_read_grant: assert property (@(posedge clk) disable iff (rst) rvalid == exp_rvalid)
    else report_mismatch("read grant", 32'($sampled(exp_rvalid)), 32'($sampled(rvalid)));

  for (genvar p = 0; p < vrf_pkg::NR_READ_PORTS; p++) begin : gen_read_checks
    // Ports without a grant return zero
    a_read_data: assert property (@(posedge clk) disable iff (rst)
      rdata[p] == (exp_rvalid[p] ? exp_rdata[p] : '0))
      else report_mismatch($sformatf("read data port %0d", p),
                           $sampled(exp_rvalid[p]) ? $sampled(exp_rdata[p]) : 32'h0,
                           $sampled(rdata[p]));
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #2;
    we = '0;
    re = '0;
  endtask

  task automatic set_write(input int unsigned port, input logic [5:0] addr,
                           input logic [31:0] data, input logic [3:0] be);
    we[port]         = 1'b1;
    waddr[port].flat = addr;
    wdata[port]      = data;
    wbe[port]        = be;
  endtask

  task automatic set_read(input int unsigned port, input logic [5:0] addr);
    re[port]         = 1'b1;
    raddr[port].flat = addr;
  endtask

  function automatic logic [5:0] rand_addr();
    logic [31:0] r;
    r = $random(seed);
    return r[5:0];
  endfunction

  task automatic start_test(input string name);
    test_name     = name;
    test_err_base = err_count;
  endtask

  task automatic end_test();
    if (err_count == test_err_base) begin
      pass_count++;
      $display("test %s passed", test_name);
    end else begin
      fail_count++;
      $display("test %s failed with %0d errors", test_name, err_count - test_err_base);
    end
  endtask

  // Three writes in one cycle and a read back of each word on a slot of its own
  task automatic write_then_read(input logic [5:0] a0, input logic [5:0] a1,
                                 input logic [5:0] a2);
    set_write(vrf_pkg::FU_WR, a0, $random(seed), 4'hf);
    set_write(vrf_pkg::LSU_WR, a1, $random(seed), 4'hf);
    set_write(vrf_pkg::SLDU_WR, a2, $random(seed), 4'hf);
    next_cycle();
    set_read(vrf_pkg::FU_VS2_RD, a0);
    set_read(vrf_pkg::FU_VS1_RD, a1);
    set_read(vrf_pkg::FU_VD_RD, a2);
    next_cycle();
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic clear_after_reset();
    start_test("reset_clear");
    for (int unsigned a = 0; a < CLEAR_CYCLES; a++) begin
      set_read(a % vrf_pkg::NR_READ_PORTS, 6'(a));
      next_cycle();
    end
    end_test();
  endtask

  task automatic write_read_back();
    start_test("write_read");
    for (int unsigned a = 0; a < 64; a++) begin
      set_write(a % vrf_pkg::NR_WRITE_PORTS, 6'(a), $random(seed), 4'hf);
      next_cycle();
    end
    for (int unsigned a = 0; a < 64; a++) begin
      set_read(a % vrf_pkg::NR_READ_PORTS, 6'(a));
      next_cycle();
    end
    end_test();
  endtask

  task automatic partial_writes();
    logic [5:0]  addr;
    logic [31:0] r;
    start_test("byte_enables");
    for (int unsigned i = 0; i < PARTIAL_CYCLES / 2; i++) begin
      addr = rand_addr();
      r    = $random(seed);
      // Keep every write partial
      if (r[3:0] == 4'hf) begin
        r[3:0] = 4'h5;
      end
      set_write(i % vrf_pkg::NR_WRITE_PORTS, addr, $random(seed), r[3:0]);
      next_cycle();
      set_read(i % vrf_pkg::NR_READ_PORTS, addr);
      next_cycle();
    end
    end_test();
  endtask

  task automatic write_arbitration();
    start_test("write_priority");
    write_then_read(6'd1, 6'd5, 6'd9);
    write_then_read(6'd4, 6'd13, 6'd22);
    for (int unsigned i = 0; i < WARB_CYCLES / 2 - 2; i++) begin
      write_then_read(rand_addr(), rand_addr(), rand_addr());
    end
    end_test();
  endtask

  task automatic read_arbitration();
    start_test("read_priority");
    set_read(vrf_pkg::FU_VS2_RD, 6'd2);
    set_read(vrf_pkg::SLDU_RD, 6'd6);
    next_cycle();
    set_read(vrf_pkg::FU_VS1_RD, 6'd3);
    set_read(vrf_pkg::LSU_RD, 6'd7);
    next_cycle();
    // Bank 0 fills all three slots and bank 1 takes the other two
    set_read(vrf_pkg::FU_VS2_RD, 6'd0);
    set_read(vrf_pkg::FU_VS1_RD, 6'd4);
    set_read(vrf_pkg::FU_VD_RD, 6'd8);
    set_read(vrf_pkg::LSU_RD, 6'd1);
    set_read(vrf_pkg::SLDU_RD, 6'd5);
    next_cycle();
    for (int unsigned i = 0; i < RARB_CYCLES - 3; i++) begin
      for (int unsigned p = 0; p < vrf_pkg::NR_READ_PORTS; p++) begin
        set_read(p, rand_addr());
      end
      next_cycle();
    end
    end_test();
  endtask

  task automatic read_during_write();
    logic [5:0] addr;
    start_test("read_during_write");
    for (int unsigned i = 0; i < RDWR_CYCLES / 2; i++) begin
      addr = rand_addr();
      set_write(i % vrf_pkg::NR_WRITE_PORTS, addr, ~ref_mem[addr], 4'hf);
      set_read(vrf_pkg::FU_VS2_RD, addr);
      next_cycle();
      set_read(vrf_pkg::FU_VS2_RD, addr);
      next_cycle();
    end
    end_test();
  endtask

  initial begin
    seed       = 3956;
    err_count  = 0;
    pass_count = 0;
    fail_count = 0;
    test_name  = "reset";
    rst        = 1'b1;
    we         = '0;
    re         = '0;
    waddr      = '0;
    wdata      = '0;
    wbe        = '0;
    raddr      = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst = 1'b0;

    clear_after_reset();
    write_read_back();
    partial_writes();
    write_arbitration();
    read_arbitration();
    read_during_write();

    $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- all.f
source/vrf_pkg.sv
source/vrf_request_router.sv
source/vrf_bank.sv
source/vrf_read_return.sv
source/vrf_top.sv
bench/vrf_tb.sv
